//--- verilog/uart_pkg.sv
// Shared types, register map and state encodings for the AXI4-Lite UART.
// Modules import this package inside their bodies and use scoped names in port lists.
package uart_pkg;

    typedef logic [7:0]  data_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  reg_addr_t;
    typedef logic [23:0] divisor_t;

    // Register word indices, from address bits 3:2
    localparam reg_addr_t ADDR_TX   = 2'd0;
    localparam reg_addr_t ADDR_RX   = 2'd1;
    localparam reg_addr_t ADDR_CFG  = 2'd2;
    localparam reg_addr_t ADDR_STAT = 2'd3;

    // CFG layout: divisor in 23:0, stop select in 27
    localparam int    CFG_STOP_BIT = 27;
    localparam word_t CFG_MASK     = 32'h08FF_FFFF;

    localparam int STAT_RX_AVAIL = 0;
    localparam int STAT_TX_SPACE = 1;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    typedef enum logic [2:0] {
        AXI_IDLE,
        AXI_WRITE_DATA,
        AXI_WRITE_RESP,
        AXI_READ_EXECUTE,
        AXI_READ_DATA,
        AXI_READ_BACK
    } axi_state_t;

    typedef enum logic [2:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP,
        UART_END
    } uart_state_t;

endpackage

//--- verilog/byte_fifo_if.sv
// Push and pop sides of one byte FIFO.
// The producer pushes with wr_en, the consumer pops with rd_en and sees dout a cycle later.
`timescale 1ns/1ps

interface byte_fifo_if;
    import uart_pkg::*;

    // Push side
    data_t din;
    logic  wr_en;
    logic  full;

    // Pop side
    data_t dout;
    logic  rd_en;
    logic  empty;

    modport producer (output din, output wr_en, input full);

    modport consumer (output rd_en, input dout, input empty);

    modport fifo (input din, input wr_en, input rd_en, output full, output dout, output empty);

endinterface

//--- verilog/byte_fifo.sv
// Synchronous byte FIFO of FIFO_DEPTH entries with a registered read port.
// Pushes while full and pops while empty are ignored.
`timescale 1ns/1ps

module byte_fifo (
    input  logic     clk,
    input  logic     rstn,
    byte_fifo_if.fifo f
);
    import uart_pkg::*;

    data_t              mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               push;
    logic               pop;

    assign push    = f.wr_en && !f.full;
    assign pop     = f.rd_en && !f.empty;
    assign f.full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign f.empty = (count == '0);

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= f.din;
        end
        // Output only moves on an accepted pop
        if (pop) begin
            f.dout <= mem[rd_ptr];
        end
    end

endmodule

//--- verilog/uart_tx.sv
// UART transmitter. Fetches bytes from the TX FIFO and sends 8N1 or 8N2 frames,
// each bit lasting divisor clock cycles, followed by one idle bit period.
`timescale 1ns/1ps

module uart_tx (
    input  logic               clk,
    input  logic               rstn,
    input  uart_pkg::divisor_t divisor,
    input  logic               two_stop,
    byte_fifo_if.consumer      q,
    output logic               tx
);
    import uart_pkg::*;

    uart_state_t state;
    divisor_t    period_cnt;
    logic [2:0]  bit_idx;
    data_t       shift;
    logic        stop2;
    logic        fetch_pend;
    logic        bit_done;

    assign bit_done = (period_cnt == divisor - divisor_t'(1));

    // Pop only while idle and no byte is already on its way
    assign q.rd_en = (state == UART_IDLE) && !fetch_pend && !q.empty;

    // Popped byte is valid on dout one cycle later
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fetch_pend <= 1'b0;
        end else begin
            fetch_pend <= q.rd_en;
        end
    end

    // Bit timer, held at zero while idle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            period_cnt <= '0;
        end else if (state == UART_IDLE || bit_done) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == UART_IDLE && fetch_pend) begin
            shift <= q.dout;
            stop2 <= two_stop;
        end else if (bit_done && (state == UART_START || state == UART_DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= UART_IDLE;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                UART_IDLE: begin
                    if (fetch_pend) begin
                        tx    <= 1'b0;
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_done) begin
                        tx      <= shift[0];
                        bit_idx <= '0;
                        state   <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            tx      <= 1'b1;
                            bit_idx <= '0;
                            state   <= UART_STOP;
                        end else begin
                            tx      <= shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                UART_STOP: begin
                    // bit_idx marks the second stop bit
                    if (bit_done) begin
                        if (stop2 && bit_idx == '0) begin
                            bit_idx <= 3'd1;
                        end else begin
                            bit_idx <= '0;
                            state   <= UART_END;
                        end
                    end
                end
                UART_END: begin
                    if (bit_done) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/uart_rx.sv
// UART receiver. Synchronizes rx, rechecks the start bit at half a period,
// samples each data bit mid-bit and pushes the byte at the first stop bit.
`timescale 1ns/1ps

module uart_rx (
    input  logic               clk,
    input  logic               rstn,
    input  uart_pkg::divisor_t divisor,
    input  logic               two_stop,
    input  logic               rx,
    byte_fifo_if.producer      q
);
    import uart_pkg::*;

    uart_state_t state;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_last;
    logic        start_edge;
    divisor_t    period_cnt;
    divisor_t    target;
    logic        tick;
    logic [2:0]  bit_idx;
    data_t       shift;

    // Two-flop synchronizer plus one more stage for edge detection
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign start_edge = rx_last && !rx_sync;

    // Half a period to the start bit center, then full periods
    assign target = (state == UART_START) ? (divisor >> 1) - divisor_t'(1)
                                          : divisor - divisor_t'(1);
    assign tick   = (period_cnt == target);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            period_cnt <= '0;
        end else if (state == UART_IDLE || tick) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == UART_DATA && tick) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    // Stop bit level is not checked
    assign q.wr_en = (state == UART_STOP) && tick;
    assign q.din   = shift;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= UART_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                UART_IDLE: begin
                    if (start_edge) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (tick) begin
                        // Line back high, glitch rather than a start bit
                        if (rx_sync) begin
                            state <= UART_IDLE;
                        end else begin
                            bit_idx <= '0;
                            state   <= UART_DATA;
                        end
                    end
                end
                UART_DATA: begin
                    if (tick) begin
                        if (bit_idx == 3'd7) begin
                            bit_idx <= '0;
                            state   <= UART_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                UART_STOP: begin
                    if (tick) begin
                        state <= two_stop ? UART_END : UART_IDLE;
                    end
                end
                UART_END: begin
                    // Waiting out the second stop bit
                    if (tick) begin
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/axi_regs.sv
// AXI4-Lite slave with the TX, RX, CFG and STATUS registers.
// One transaction at a time; writes win over reads when both arrive together.
`timescale 1ns/1ps

module axi_regs (
    input  logic               clk,
    input  logic               rstn,
    input  logic [11:0]        awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  uart_pkg::word_t    wdata,
    input  uart_pkg::strb_t    wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic               bvalid,
    input  logic               bready,
    input  logic [11:0]        araddr,
    input  logic               arvalid,
    output logic               arready,
    output uart_pkg::word_t    rdata,
    output logic               rvalid,
    input  logic               rready,
    byte_fifo_if.producer      txq,
    byte_fifo_if.consumer      rxq,
    output uart_pkg::divisor_t divisor,
    output logic               two_stop
);
    import uart_pkg::*;

    axi_state_t state;
    reg_addr_t  aw_idx;
    reg_addr_t  ar_idx;
    word_t      wdata_q;
    strb_t      wstrb_q;
    word_t      rdata_q;
    word_t      cfg;
    word_t      strb_mask;
    word_t      stat_word;
    word_t      rd_word;
    logic       rx_hit;

    assign awready = (state == AXI_IDLE);
    assign arready = (state == AXI_IDLE);
    assign wready  = (state == AXI_WRITE_DATA);
    assign bvalid  = (state == AXI_WRITE_RESP);
    assign rvalid  = (state == AXI_READ_BACK);
    assign rdata   = rdata_q;

    assign divisor  = cfg[$bits(divisor_t)-1:0];
    assign two_stop = cfg[CFG_STOP_BIT];

    // TX push lands together with the write response handshake
    assign txq.din   = wdata_q[7:0];
    assign txq.wr_en = (state == AXI_WRITE_RESP) && bready && (aw_idx == ADDR_TX) && wstrb_q[0];

    assign rxq.rd_en = (state == AXI_READ_EXECUTE) && (ar_idx == ADDR_RX);

    always_comb begin
        for (int i = 0; i < $bits(strb_t); i++) begin
            strb_mask[8*i +: 8] = {8{wstrb_q[i]}};
        end
    end

    always_comb begin
        stat_word                = '0;
        stat_word[STAT_RX_AVAIL] = !rxq.empty;
        stat_word[STAT_TX_SPACE] = !txq.full;
    end

    always_comb begin
        case (ar_idx)
            // Empty FIFO reads back as zero
            ADDR_RX:   rd_word = rx_hit ? word_t'(rxq.dout) : '0;
            ADDR_CFG:  rd_word = cfg;
            ADDR_STAT: rd_word = stat_word;
            default:   rd_word = '0;
        endcase
    end

    // Address, data and read result capture
    always_ff @(posedge clk) begin
        case (state)
            AXI_IDLE: begin
                if (awvalid) begin
                    aw_idx <= awaddr[3:2];
                end else if (arvalid) begin
                    ar_idx <= araddr[3:2];
                end
            end
            AXI_WRITE_DATA: begin
                if (wvalid) begin
                    wdata_q <= wdata;
                    wstrb_q <= wstrb;
                end
            end
            AXI_READ_EXECUTE: rx_hit  <= rxq.rd_en && !rxq.empty;
            AXI_READ_DATA:    rdata_q <= rd_word;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= AXI_IDLE;
            cfg   <= '0;
        end else begin
            case (state)
                AXI_IDLE: begin
                    if (awvalid) begin
                        state <= AXI_WRITE_DATA;
                    end else if (arvalid) begin
                        state <= AXI_READ_EXECUTE;
                    end
                end
                AXI_WRITE_DATA: begin
                    if (wvalid) begin
                        state <= AXI_WRITE_RESP;
                    end
                end
                AXI_WRITE_RESP: begin
                    if (bready) begin
                        state <= AXI_IDLE;
                        // Bytewise merge, reserved bits forced to zero
                        if (aw_idx == ADDR_CFG) begin
                            cfg <= ((wdata_q & strb_mask) | (cfg & ~strb_mask)) & CFG_MASK;
                        end
                    end
                end
                AXI_READ_EXECUTE: state <= AXI_READ_DATA;
                AXI_READ_DATA:    state <= AXI_READ_BACK;
                AXI_READ_BACK: begin
                    if (rready) begin
                        state <= AXI_IDLE;
                    end
                end
                default: state <= AXI_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/uart_axi.sv
// Top level of the AXI4-Lite UART. Connects the register slave, the two byte FIFOs,
// the transmitter and the receiver. Both bus responses are always OKAY.
`timescale 1ns/1ps

module uart_axi (
    input  logic            clk,
    input  logic            rstn,
    input  logic [11:0]     awaddr,
    input  logic [2:0]      awprot,
    input  logic            awvalid,
    output logic            awready,
    input  uart_pkg::word_t wdata,
    input  uart_pkg::strb_t wstrb,
    input  logic            wvalid,
    output logic            wready,
    output logic [1:0]      bresp,
    output logic            bvalid,
    input  logic            bready,
    input  logic [11:0]     araddr,
    input  logic [2:0]      arprot,
    input  logic            arvalid,
    output logic            arready,
    output uart_pkg::word_t rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  logic            rready,
    input  logic            rx,
    output logic            tx
);
    import uart_pkg::*;

    divisor_t divisor;
    logic     two_stop;

    // awprot and arprot carry no meaning for this peripheral
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    byte_fifo_if i_txq ();
    byte_fifo_if i_rxq ();

    byte_fifo i_tx_fifo (.clk(clk), .rstn(rstn), .f(i_txq.fifo));

    byte_fifo i_rx_fifo (.clk(clk), .rstn(rstn), .f(i_rxq.fifo));

    axi_regs i_axi_regs (
        .clk     (clk),
        .rstn    (rstn),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .txq     (i_txq.producer),
        .rxq     (i_rxq.consumer),
        .divisor (divisor),
        .two_stop(two_stop)
    );

    uart_tx i_uart_tx (
        .clk     (clk),
        .rstn    (rstn),
        .divisor (divisor),
        .two_stop(two_stop),
        .q       (i_txq.consumer),
        .tx      (tx)
    );

    uart_rx i_uart_rx (
        .clk     (clk),
        .rstn    (rstn),
        .divisor (divisor),
        .two_stop(two_stop),
        .rx      (rx),
        .q       (i_rxq.producer)
    );

endmodule

//--- sim/tb_uart_axi.sv
// Self-checking testbench for the AXI4-Lite UART.
// Checks the register map over AXI, the frames sent on tx and the bytes received on rx.
// Build and run it with the Makefile in the project root.
`timescale 1ns/1ps

module tb_uart_axi;
    import uart_pkg::*;

    localparam logic [11:0] TX_ADDR   = 12'h000;
    localparam logic [11:0] RX_ADDR   = 12'h004;
    localparam logic [11:0] CFG_ADDR  = 12'h008;
    localparam logic [11:0] STAT_ADDR = 12'h00C;
    localparam word_t       CFG_WRITABLE = 32'h08FF_FFFF;
    localparam int          STOP_SEL     = 27;
    // 6 frames at divisor 8, 6 at 11, 5 received at 11
    localparam int WATCHDOG_NS = 2 * (12 * 4 * (6 * 8 + 6 * 11 + 5 * 11)) + 10000;

    logic        clk;
    logic        rstn;
    logic [11:0] awaddr;
    logic [2:0]  awprot;
    logic        awvalid;
    logic        awready;
    word_t       wdata;
    strb_t       wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic [2:0]  arprot;
    logic        arvalid;
    logic        arready;
    word_t       rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        rx;
    logic        tx;

    data_t tx_expect[$];
    int    tx_frames_seen;
    int    cur_divisor;
    logic  cur_two_stop;
    logic  tx_prev_valid;
    time   tx_prev_start;
    word_t cfg_model;

    uart_axi i_uart_axi (
        .clk(clk), .rstn(rstn),
        .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .rx(rx), .tx(tx)
    );

    always #2 clk = ~clk;

    // Line levels of one frame, LSB first; bit 10 is the second stop or the idle bit
    function automatic logic [10:0] frame_bits(input data_t value, input logic two,
                                               output int nbits);
        logic [10:0] bits;
        bits      = '1;
        bits[0]   = 1'b0;
        bits[8:1] = value;
        nbits     = two ? 11 : 10;
        return bits;
    endfunction

    function automatic word_t cfg_merge(input word_t old_v, input word_t new_v, input strb_t strb);
        word_t merged;
        merged = old_v;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return merged & CFG_WRITABLE;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            abort_run($sformatf("Error %s: expected 0x%08h, actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [11:0] addr, input word_t data, input strb_t strb);
        int delay;
        step_cycle();
        awaddr  = addr;
        awvalid = 1'b1;
        while (!awready) begin
            step_cycle();
        end
        step_cycle();
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        while (!wready) begin
            step_cycle();
        end
        step_cycle();
        wvalid = 1'b0;
        // Random back-pressure on the response
        delay = $urandom_range(3, 0);
        repeat (delay) step_cycle();
        bready = 1'b1;
        while (!bvalid) begin
            step_cycle();
        end
        check_equal("bresp", 32'h0, 32'(bresp));
        step_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output word_t data);
        int    delay;
        int    cycles;
        word_t first;
        step_cycle();
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            step_cycle();
        end
        step_cycle();
        arvalid = 1'b0;
        cycles  = 1;
        while (!rvalid) begin
            step_cycle();
            cycles++;
        end
        check_equal("rvalid latency", 32'd3, 32'(cycles));
        first = rdata;
        delay = $urandom_range(3, 0);
        repeat (delay) step_cycle();
        rready = 1'b1;
        check_equal("rdata held under back-pressure", first, rdata);
        check_equal("rresp", 32'h0, 32'(rresp));
        data = rdata;
        step_cycle();
        rready = 1'b0;
    endtask

    task automatic send_rx_frame(input data_t value);
        logic [10:0] bits;
        int          nbits;
        bits = frame_bits(value, cur_two_stop, nbits);
        step_cycle();
        for (int k = 0; k < nbits; k++) begin
            rx = bits[k];
            repeat (cur_divisor) @(posedge clk);
            #1;
        end
        rx = 1'b1;
        repeat (cur_divisor) @(posedge clk);
    endtask

    task automatic run_tx_burst(input int divisor, input logic two, input int count);
        word_t cfg_word;
        data_t value;
        int    target;
        cfg_word           = word_t'(divisor);
        cfg_word[STOP_SEL] = two;
        axi_write(CFG_ADDR, cfg_word, 4'hF);
        cfg_model     = cfg_word;
        cur_divisor   = divisor;
        cur_two_stop  = two;
        tx_prev_valid = 1'b0;
        target        = tx_frames_seen + count;
        for (int n = 0; n < count; n++) begin
            value = data_t'($urandom);
            tx_expect.push_back(value);
            axi_write(TX_ADDR, (word_t'($urandom) & 32'hFFFF_FF00) | word_t'(value),
                      strb_t'($urandom) | 4'b0001);
        end
        wait (tx_frames_seen == target);
        // Let the last idle bit pass before the config changes
        repeat (2 * divisor) step_cycle();
    endtask

    // Serial monitor on tx, sampling each bit at its middle
    initial begin : tx_monitor
        logic [10:0] exp_bits;
        data_t       exp_byte;
        int          nbits;
        int          bit_ns;
        time         t_start;
        wait (rstn);
        forever begin
            @(negedge tx);
            t_start = $time;
            if (tx_expect.size() == 0) begin
                abort_run("A frame started on tx although no byte was written to TX");
            end
            exp_byte = tx_expect.pop_front();
            exp_bits = frame_bits(exp_byte, cur_two_stop, nbits);
            bit_ns   = cur_divisor * 4;
            if (tx_prev_valid) begin
                assert (t_start - tx_prev_start >= time'((nbits + 1) * bit_ns)) else begin
                    abort_run("A start bit on tx came before the stop and idle bits had ended");
                end
            end
            tx_prev_start = t_start;
            tx_prev_valid = 1'b1;
            #(bit_ns / 2 + 1);
            for (int k = 0; k < nbits; k++) begin
                if (k > 0) begin
                    #(bit_ns);
                end
                check_equal($sformatf("tx frame %0d bit %0d", tx_frames_seen, k),
                            32'(exp_bits[k]), 32'(tx));
            end
            tx_frames_seen++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Timeout: the run took longer than the frame budget allows");
    end

    initial begin : main_sequence
        word_t data;
        word_t value;
        strb_t strb;
        data_t rx_sent[$];
        data_t b;
        void'($urandom(32'h8e0fa03e));
        clk     = 1'b0;
        rstn    = 1'b0;
        awaddr  = '0;
        awprot  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arprot  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        rx      = 1'b1;
        tx_frames_seen = 0;
        cur_divisor    = 8;
        cur_two_stop   = 1'b0;
        tx_prev_valid  = 1'b0;
        tx_prev_start  = 0;
        cfg_model      = '0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        step_cycle();

        // Reset state
        check_equal("reset tx", 32'h1, 32'(tx));
        check_equal("reset bvalid", 32'h0, 32'(bvalid));
        check_equal("reset rvalid", 32'h0, 32'(rvalid));
        check_equal("reset wready", 32'h0, 32'(wready));
        check_equal("reset awready", 32'h1, 32'(awready));
        check_equal("reset arready", 32'h1, 32'(arready));
        axi_read(CFG_ADDR, data);
        check_equal("reset cfg", 32'h0, data);
        axi_read(STAT_ADDR, data);
        check_equal("reset status", 32'h2, data);

        // CFG merge under random strobes
        for (int n = 0; n < 12; n++) begin
            value = $urandom;
            strb  = strb_t'($urandom);
            axi_write(CFG_ADDR, value, strb);
            cfg_model = cfg_merge(cfg_model, value, strb);
            axi_read(CFG_ADDR, data);
            check_equal($sformatf("cfg write %0d", n), cfg_model, data);
        end

        run_tx_burst(8, 1'b0, 6);
        run_tx_burst(11, 1'b1, 6);

        // Receive path, still at divisor 11 with two stop bits
        for (int n = 0; n < 5; n++) begin
            b = data_t'($urandom);
            rx_sent.push_back(b);
            send_rx_frame(b);
        end
        axi_read(STAT_ADDR, data);
        check_equal("status with rx data", 32'h3, data);
        for (int n = 0; n < 5; n++) begin
            axi_read(RX_ADDR, data);
            check_equal($sformatf("rx byte %0d", n), word_t'(rx_sent[n]), data);
        end
        axi_read(STAT_ADDR, data);
        check_equal("status after rx reads", 32'h2, data);
        axi_read(RX_ADDR, data);
        check_equal("rx read while empty", 32'h0, data);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- sim.f
verilog/uart_pkg.sv
verilog/byte_fifo_if.sv
verilog/byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/axi_regs.sv
verilog/uart_axi.sv
sim/tb_uart_axi.sv

//--- Makefile
# Verilator build for the AXI4-Lite UART and its testbench.
# make lint, make sim, make clean. The sim exit status is the test result.

TOP := tb_uart_axi

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
